// File: ifu_aligner.f
ifu_aln_pkg.sv
ifu_aln_if.sv
ifu_aln_buffer.sv
ifu_aln_valid_ctl.sv
ifu_aln_align.sv
ifu_aligner.sv
tb_clock_gen.sv
ifu_aligner_tb.sv

// File: ifu_aligner.sv
//******************
// instruction aligner top
// fetch buffer, valid control and aligner datapath
//******************

`timescale 1ns/1ps

module ifu_aligner (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ifu_aln_pkg::half_flags_t  fetch_val,
   input  ifu_aln_pkg::pc_t          fetch_pc,
   input  ifu_aln_pkg::fetch_word_t  fetch_data,
   input  ifu_aln_pkg::half_flags_t  fetch_icaf,
   input  ifu_aln_pkg::fault_type_t  fetch_icaf_type,
   input  ifu_aln_pkg::half_flags_t  fetch_dbecc,
   input  logic                      async_error_start,
   input  logic                      flush,
   input  logic                      decode,
   output logic                      i0_valid,
   output ifu_aln_pkg::fetch_word_t  i0_instr,
   output ifu_aln_pkg::pc_t          i0_pc,
   output logic                      i0_pc4,
   output logic                      i0_icaf,
   output ifu_aln_pkg::fault_type_t  i0_icaf_type,
   output logic                      i0_icaf_second,
   output logic                      i0_dbecc,
   output logic                      fb_consume1,
   output logic                      fb_consume2
);

   fb_view_if   u_view ();
   aln_shift_if u_shift ();

   ifu_aln_buffer u_buffer (
      .clk             (clk),
      .arst_n          (arst_n),
      .fetch_val       (fetch_val),
      .fetch_pc        (fetch_pc),
      .fetch_data      (fetch_data),
      .fetch_icaf      (fetch_icaf),
      .fetch_dbecc     (fetch_dbecc),
      .fetch_icaf_type (fetch_icaf_type),
      .flush           (flush),
      .view            (u_view.buffer),
      .ctl             (u_shift.buffer)
   );

   ifu_aln_valid_ctl u_valid_ctl (
      .clk               (clk),
      .arst_n            (arst_n),
      .fetch_val         (fetch_val),
      .async_error_start (async_error_start),
      .flush             (flush),
      .ctl               (u_shift.valid_ctl)
   );

   ifu_aln_align u_align (
      .view           (u_view.aligner),
      .ctl            (u_shift.aligner),
      .decode         (decode),
      .i0_valid       (i0_valid),
      .i0_instr       (i0_instr),
      .i0_pc          (i0_pc),
      .i0_pc4         (i0_pc4),
      .i0_icaf        (i0_icaf),
      .i0_icaf_second (i0_icaf_second),
      .i0_dbecc       (i0_dbecc),
      .i0_icaf_type   (i0_icaf_type)
   );

   // buffer balance back to fetch
   assign fb_consume1 = u_shift.consume1;
   assign fb_consume2 = u_shift.consume2;

endmodule

// File: ifu_aligner_tb.sv
//******************
// ifu aligner testbench
// halfword stream model with immediate assertions on the
// aligned instruction, its fault flags and the consume pulses
//******************

`timescale 1ns/1ps

module ifu_aligner_tb;
   import ifu_aln_pkg::*;

   typedef struct packed {
      half_t       data;
      pc_t         pc;
      logic        icaf;
      logic        dbecc;
      fault_type_t itype;
      logic        last;          // final half of its fetch
   } half_ent_t;

   logic        clk, arst_n;
   half_flags_t fetch_val, fetch_icaf, fetch_dbecc;
   pc_t         fetch_pc;
   fetch_word_t fetch_data;
   fault_type_t fetch_icaf_type;
   logic        async_error_start, flush, decode;
   logic        i0_valid, i0_pc4, i0_icaf, i0_icaf_second, i0_dbecc;
   fetch_word_t i0_instr;
   pc_t         i0_pc;
   fault_type_t i0_icaf_type;
   logic        fb_consume1, fb_consume2;
   logic [5:0]  cur_flags, prev_flags;

   half_ent_t   hq[$];           // halfwords fetched, not yet taken
   int          occ;             // buffers held
   logic        stall_m;
   pc_t         next_pc;
   bit          only4, faults_on, single_on;
   int          errors, checks, tests, test_err0;
   logic        prev_hold;
   fetch_word_t prev_instr;
   pc_t         prev_pc;

   tb_clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

   ifu_aligner u_ifu_aligner (.*);

   assign cur_flags = {i0_pc4, i0_icaf, i0_icaf_second, i0_dbecc, i0_icaf_type};

   // ******************
   // model helpers
   // ******************

   function automatic half_ent_t make_half(input half_t d, input pc_t pc, input logic icaf,
                                           input logic dbecc, input fault_type_t t,
                                           input logic last);
      half_ent_t h;
      h.data  = d;
      h.pc    = pc;
      h.icaf  = icaf;
      h.dbecc = dbecc;
      h.itype = t;
      h.last  = last;
      return h;
   endfunction

   // a whole instruction sits at the head
   function automatic bit head_ready();
      if (hq.size() == 0)
         return 1'b0;
      return (hq[0].data[1:0] != 2'b11) || (hq.size() > 1);
   endfunction

   function automatic half_flags_t fault_bits();
      return {$urandom_range(0, 4) == 0, $urandom_range(0, 4) == 0};
   endfunction

   task automatic flag_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      errors++;
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
   endtask

   // ******************
   // per cycle check and model update
   // ******************

   task automatic check_cycle();
      half_ent_t   h0, h1;
      logic        is4, exp_valid, take, clean0, exp_c1, exp_c2;
      int          n_last;
      fetch_word_t exp_instr;
      logic [5:0]  exp_flags;
      h0        = '0;
      h1        = '0;
      n_last    = 0;
      exp_valid = head_ready();
      if (hq.size() > 0)
         h0 = hq[0];
      if (hq.size() > 1)
         h1 = hq[1];
      is4  = h0.data[1:0] == 2'b11;
      take = exp_valid && decode && !stall_m;
      if (take)
         n_last = int'(h0.last) + (is4 ? int'(h1.last) : 0);   // buffers emptied
      exp_c1 = !flush && (n_last == 1);
      exp_c2 = !flush && (n_last == 2);
      checks++;

      a_valid: assert (i0_valid === exp_valid)
         else flag_mismatch("i0_valid", 32'(i0_valid), 32'(exp_valid));
      a_consume1: assert (fb_consume1 === exp_c1)
         else flag_mismatch("fb_consume1", 32'(fb_consume1), 32'(exp_c1));
      a_consume2: assert (fb_consume2 === exp_c2)
         else flag_mismatch("fb_consume2", 32'(fb_consume2), 32'(exp_c2));

      if (exp_valid) begin
         clean0    = !(h0.icaf || h0.dbecc);
         exp_instr = is4 ? {h1.data, h0.data} : {16'h0, h0.data};
         exp_flags = is4 ? {1'b1, h0.icaf | h1.icaf, clean0 & (h1.icaf | h1.dbecc),
                            h0.dbecc | h1.dbecc, clean0 ? h1.itype : h0.itype}
                         : {1'b0, h0.icaf, 1'b0, h0.dbecc, h0.itype};
         a_instr: assert (i0_instr === exp_instr)
            else flag_mismatch("i0_instr", i0_instr, exp_instr);
         a_pc: assert (i0_pc === h0.pc)
            else flag_mismatch("i0_pc", 32'(i0_pc), 32'(h0.pc));
         a_flags: assert (cur_flags === exp_flags)
            else flag_mismatch("{pc4,icaf,icaf_second,dbecc,icaf_type}",
                               32'(cur_flags), 32'(exp_flags));
      end

      // untaken instruction must not move
      if (prev_hold) begin
         a_hold: assert (i0_valid && i0_instr === prev_instr && i0_pc === prev_pc &&
                         cur_flags === prev_flags)
            else begin
               errors++;
               $display("FAIL %0t ns: outputs changed while the instruction was held", $time);
            end
      end
      prev_hold  = exp_valid && !take && !flush;
      prev_instr = i0_instr;
      prev_pc    = i0_pc;
      prev_flags = cur_flags;

      if (take) begin
         void'(hq.pop_front());
         if (is4)
            void'(hq.pop_front());
         occ -= n_last;
      end
      if (flush) begin
         hq.delete();
         occ = 0;
      end else if (fetch_val[0]) begin
         hq.push_back(make_half(fetch_data[15:0], fetch_pc, fetch_icaf[0], fetch_dbecc[0],
                                fetch_icaf_type, !fetch_val[1]));
         if (fetch_val[1])
            hq.push_back(make_half(fetch_data[31:16], fetch_pc + pc_t'(1), fetch_icaf[1],
                                   fetch_dbecc[1], fetch_icaf_type, 1'b1));
         occ++;
      end
      stall_m = (stall_m || async_error_start) && !flush;
   endtask

   // drive at the rising edge, check mid cycle
   task automatic run_cycle(input bit want_fetch, input bit dec, input bit do_flush,
                            input bit err);
      half_t       lo, hi;
      half_flags_t val;
      @(posedge clk);
      if (want_fetch && !do_flush && occ < NUM_FB) begin
         lo  = half_t'($urandom);
         hi  = half_t'($urandom);
         val = 2'b11;
         if (only4)
            lo[1:0] = 2'b11;
         else if (single_on && $urandom_range(0, 3) == 0)
            val = 2'b01;                          // high half left as garbage
         fetch_val       <= val;
         fetch_pc        <= next_pc;
         fetch_data      <= {hi, lo};
         fetch_icaf      <= faults_on ? fault_bits() : 2'b00;
         fetch_dbecc     <= faults_on ? fault_bits() : 2'b00;
         fetch_icaf_type <= fault_type_t'($urandom);
         next_pc = next_pc + ((val == 2'b11) ? pc_t'(2) : pc_t'(1));
      end else begin
         fetch_val <= 2'b00;
      end
      decode            <= dec;
      flush             <= do_flush;
      async_error_start <= err;
      @(negedge clk);
      check_cycle();
   endtask

   // take what is complete, then flush away a lone first half
   task automatic drain();
      int n;
      n = 0;
      while (head_ready() && n < 64) begin
         run_cycle(1'b0, 1'b1, 1'b0, 1'b0);
         n++;
      end
      if (head_ready()) begin
         errors++;
         $display("timeout: the aligner did not drain within 64 cycles");
      end
      run_cycle(1'b0, 1'b1, 1'b1, 1'b0);
      run_cycle(1'b0, 1'b1, 1'b0, 1'b0);
      next_pc = pc_t'($urandom);
   endtask

   task automatic test_done(input string name);
      string verdict;
      if (errors == test_err0)
         verdict = "ok";
      else
         verdict = "failed";
      tests++;
      $display("test %-14s %s, %0d errors", name, verdict, errors - test_err0);
      test_err0 = errors;
   endtask

   // ******************
   // test sequence
   // ******************

   initial begin
      int i, k, stretch;
      bit dec;
      fetch_val         = '0;
      fetch_pc          = '0;
      fetch_data        = '0;
      fetch_icaf        = '0;
      fetch_dbecc       = '0;
      fetch_icaf_type   = '0;
      async_error_start = 1'b0;
      flush             = 1'b0;
      decode            = 1'b0;
      occ       = 0;
      stall_m   = 1'b0;
      prev_hold = 1'b0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      test_err0 = 0;
      only4     = 1'b0;
      faults_on = 1'b0;
      single_on = 1'b0;
      void'($urandom(32'h536e));
      next_pc = pc_t'($urandom);

      i = 0;
      while (arst_n !== 1'b1 && i < 20) begin
         @(posedge clk);
         i++;
      end
      if (arst_n !== 1'b1) begin
         errors++;
         $display("timeout: reset was never released");
      end

      for (i = 0; i < 10; i++)
         run_cycle(1'b0, 1'b1, 1'b0, 1'b0);
      test_done("reset_idle");

      only4 = 1'b1;
      for (i = 0; i < 24; i++)
         run_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      drain();
      only4 = 1'b0;
      test_done("aligned_4b");

      single_on = 1'b1;
      for (i = 0; i < 200; i++)
         run_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 7) != 0, 1'b0, 1'b0);
      drain();
      test_done("random_mix");

      stretch = 0;
      dec     = 1'b1;
      for (i = 0; i < 150; i++) begin
         if (stretch == 0) begin
            dec     = !dec;
            stretch = $urandom_range(1, 6);
         end
         stretch--;
         run_cycle($urandom_range(0, 1) == 1, dec, 1'b0, 1'b0);
      end
      drain();
      test_done("backpressure");

      for (i = 0; i < 4; i++)
         run_cycle(1'b1, 1'b0, 1'b0, 1'b0);
      run_cycle(1'b1, 1'b1, 1'b0, 1'b1);          // stall starts here
      for (i = 0; i < 20; i++)
         run_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      run_cycle(1'b0, 1'b1, 1'b1, 1'b0);
      next_pc = pc_t'($urandom);
      for (i = 0; i < 10; i++)
         run_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      drain();
      test_done("error_stall");

      k = $urandom_range(5, 30);
      for (i = 0; i < k; i++)
         run_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0, 1'b0, 1'b0);
      run_cycle(1'b0, $urandom_range(0, 1) == 1, 1'b1, 1'b0);
      next_pc = pc_t'($urandom);                  // new stream after the flush
      for (i = 0; i < 40; i++)
         run_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0, 1'b0, 1'b0);
      drain();
      test_done("flush");

      faults_on = 1'b1;
      for (i = 0; i < 250; i++)
         run_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 5) != 0, 1'b0, 1'b0);
      drain();
      faults_on = 1'b0;
      test_done("faults");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: ifu_aln_align.sv
//******************
// aligner datapath
// builds the next 2B or 4B instruction with its flags and
// works out the shift for the take
//******************

`timescale 1ns/1ps

module ifu_aln_align (
   fb_view_if.aligner                view,
   aln_shift_if.aligner              ctl,
   input  logic                      decode,
   output logic                      i0_valid,
   output ifu_aln_pkg::fetch_word_t  i0_instr,
   output ifu_aln_pkg::pc_t          i0_pc,
   output logic                      i0_pc4,
   output logic                      i0_icaf,
   output logic                      i0_icaf_second,
   output logic                      i0_dbecc,
   output ifu_aln_pkg::fault_type_t  i0_icaf_type
);
   import ifu_aln_pkg::*;

   fetch_word_t aligndata;
   half_flags_t alignval;
   half_flags_t alignicaf;
   half_flags_t aligndbecc;
   half_flags_t icaf_eff;
   logic        f0_full;        // both halves of f0 valid
   logic        straddle;       // only the low half of f0, rest in f1
   logic        first4b;
   logic        take;

   assign f0_full  = ctl.f0val[1];
   assign straddle = ~ctl.f0val[1] & ctl.f0val[0];

   // ******************
   // join f0 and f1
   // ******************

   always_comb begin
      aligndata  = view.f0_data;
      alignval   = '0;
      alignicaf  = view.f0_icaf;
      aligndbecc = view.f0_dbecc;
      if (f0_full) begin
         alignval = 2'b11;
      end else if (straddle) begin
         aligndata  = {view.f1_data, view.f0_data[15:0]};
         alignval   = {ctl.f1val[0], 1'b1};
         alignicaf  = {view.f1_icaf[0], view.f0_icaf[0]};
         aligndbecc = {view.f1_dbecc[0], view.f0_dbecc[0]};
      end
   end

   assign first4b  = aligndata[1:0] == 2'b11;

   assign i0_valid = first4b ? alignval[1] : alignval[0];
   assign i0_pc    = view.f0_pc;
   assign i0_pc4   = first4b;

   // 2B goes out raw in the low half
   assign i0_instr = !i0_valid ? '0 :
                     first4b   ? aligndata : {16'b0, aligndata[15:0]};

   // ******************
   // fault flags
   // ******************

   // a fault on any half faults the whole instruction
   assign i0_icaf  = first4b ? |alignicaf  : alignicaf[0];
   assign i0_dbecc = first4b ? |aligndbecc : aligndbecc[0];

   assign icaf_eff       = alignicaf | aligndbecc;
   assign i0_icaf_second = first4b & ~icaf_eff[0] & icaf_eff[1];

   // type of f1 only if the fault sits in the second fetch
   assign i0_icaf_type = (first4b && straddle && !alignicaf[0] && !aligndbecc[0]) ?
                         view.f1_ictype : view.f0_ictype;

   // ******************
   // shift
   // ******************

   assign take         = i0_valid & decode & ~ctl.error_stall;
   assign ctl.shift_2b = take & ~first4b;
   assign ctl.shift_4b = take &  first4b;

   assign ctl.f0_shift_2b = (ctl.shift_2b & ctl.f0val[0]) |
                            (ctl.shift_4b & straddle);
   assign ctl.f1_shift_2b = ctl.shift_4b & straddle;   // upper half came from f1

endmodule

// File: ifu_aln_buffer.sv
//******************
// aligner fetch buffer
// three entries written round robin, read from the oldest,
// rotated into the f0/f1 view with the half offsets applied
//******************

`timescale 1ns/1ps

module ifu_aln_buffer (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ifu_aln_pkg::half_flags_t  fetch_val,
   input  ifu_aln_pkg::pc_t          fetch_pc,
   input  ifu_aln_pkg::fetch_word_t  fetch_data,
   input  ifu_aln_pkg::half_flags_t  fetch_icaf,
   input  ifu_aln_pkg::half_flags_t  fetch_dbecc,
   input  ifu_aln_pkg::fault_type_t  fetch_icaf_type,
   input  logic                      flush,
   fb_view_if.buffer                 view,
   aln_shift_if.buffer               ctl
);
   import ifu_aln_pkg::*;

   // entry payload
   fetch_word_t data_q   [NUM_FB];
   pc_t         pc_q     [NUM_FB];
   half_flags_t icaf_q   [NUM_FB];
   half_flags_t dbecc_q  [NUM_FB];
   fault_type_t ictype_q [NUM_FB];

   fb_ptr_t            wrptr, wrptr_in;
   fb_ptr_t            rdptr, rdptr_in;
   fb_ptr_t            rdptr1;              // entry behind f0
   logic [NUM_FB-1:0]  qwen;
   logic [NUM_FB-1:0]  off_q, off_in;       // low half already used
   logic               off0, off1;

   fetch_word_t        e0_data, e1_data;
   half_flags_t        e0_icaf, e1_icaf;
   half_flags_t        e0_dbecc, e1_dbecc;

   // ring add with wrap at NUM_FB
   function automatic fb_ptr_t ptr_add(input fb_ptr_t ptr, input logic [1:0] step);
      logic [2:0] sum;
      sum = {1'b0, ptr} + {1'b0, step};
      if (sum >= 3'(NUM_FB)) begin
         sum = sum - 3'(NUM_FB);
      end
      return sum[1:0];
   endfunction

   // ******************
   // pointers and offsets
   // ******************

   assign rdptr1 = ptr_add(rdptr, 2'd1);

   always_comb begin
      for (int i = 0; i < NUM_FB; i++) begin
         qwen[i] = fetch_val[0] && (wrptr == fb_ptr_t'(i));
      end
   end

   always_comb begin
      if (flush)
         wrptr_in = '0;
      else if (fetch_val[0])
         wrptr_in = ptr_add(wrptr, 2'd1);
      else
         wrptr_in = wrptr;
   end

   // consume pulses are already masked by flush
   always_comb begin
      if (flush)
         rdptr_in = '0;
      else if (ctl.consume2)
         rdptr_in = ptr_add(rdptr, 2'd2);
      else if (ctl.consume1)
         rdptr_in = rdptr1;
      else
         rdptr_in = rdptr;
   end

   // a fresh write clears the offset of its entry
   always_comb begin
      for (int i = 0; i < NUM_FB; i++) begin
         off_in[i] = 1'b0;
         if (!qwen[i] && !flush) begin
            if (rdptr == fb_ptr_t'(i))
               off_in[i] = off_q[i] | ctl.f0_shift_2b;
            else if (rdptr1 == fb_ptr_t'(i))
               off_in[i] = off_q[i] | ctl.f1_shift_2b;
            else
               off_in[i] = off_q[i];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wrptr <= '0;
         rdptr <= '0;
         off_q <= '0;
      end else begin
         wrptr <= wrptr_in;
         rdptr <= rdptr_in;
         off_q <= off_in;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_FB; i++) begin
         if (qwen[i]) begin
            data_q[i]   <= fetch_data;
            pc_q[i]     <= fetch_pc;
            icaf_q[i]   <= fetch_icaf;
            dbecc_q[i]  <= fetch_dbecc;
            ictype_q[i] <= fetch_icaf_type;
         end
      end
   end

   // ******************
   // rotated view
   // ******************

   assign off0     = off_q[rdptr];
   assign off1     = off_q[rdptr1];
   assign e0_data  = data_q[rdptr];
   assign e1_data  = data_q[rdptr1];
   assign e0_icaf  = icaf_q[rdptr];
   assign e1_icaf  = icaf_q[rdptr1];
   assign e0_dbecc = dbecc_q[rdptr];
   assign e1_dbecc = dbecc_q[rdptr1];

   // offset moves the high half down
   assign view.f0_data   = off0 ? {16'b0, e0_data[31:16]} : e0_data;
   assign view.f1_data   = off1 ? e1_data[31:16] : e1_data[15:0];
   assign view.f0_pc     = off0 ? pc_t'(pc_q[rdptr] + pc_t'(1)) : pc_q[rdptr];
   assign view.f0_icaf   = off0 ? {1'b0, e0_icaf[1]} : e0_icaf;
   assign view.f1_icaf   = off1 ? {1'b0, e1_icaf[1]} : e1_icaf;
   assign view.f0_dbecc  = off0 ? {1'b0, e0_dbecc[1]} : e0_dbecc;
   assign view.f1_dbecc  = off1 ? {1'b0, e1_dbecc[1]} : e1_dbecc;
   assign view.f0_ictype = ictype_q[rdptr];
   assign view.f1_ictype = ictype_q[rdptr1];

   // both rings stay inside the three entries
   a_ptr_range: assert property (@(posedge clk) disable iff (!arst_n)
      (wrptr < fb_ptr_t'(NUM_FB)) && (rdptr < fb_ptr_t'(NUM_FB)));

endmodule

// File: ifu_aln_if.sv
//******************
// aligner interfaces
// fb_view_if carries the rotated buffer view to the aligner,
// aln_shift_if the valids, shift amounts and consume pulses
//******************

`timescale 1ns/1ps

interface fb_view_if;
   import ifu_aln_pkg::*;

   fetch_word_t f0_data;      // oldest entry, offset already applied
   half_t       f1_data;      // next halfword after f0
   pc_t         f0_pc;        // pc of first valid half of f0
   half_flags_t f0_icaf;
   half_flags_t f1_icaf;
   half_flags_t f0_dbecc;
   half_flags_t f1_dbecc;
   fault_type_t f0_ictype;
   fault_type_t f1_ictype;

   modport buffer (
      output f0_data, f1_data, f0_pc,
      output f0_icaf, f1_icaf, f0_dbecc, f1_dbecc,
      output f0_ictype, f1_ictype
   );

   modport aligner (
      input f0_data, f1_data, f0_pc,
      input f0_icaf, f1_icaf, f0_dbecc, f1_dbecc,
      input f0_ictype, f1_ictype
   );

endinterface

interface aln_shift_if;
   import ifu_aln_pkg::*;

   half_flags_t f0val;        // halfword valids of f0
   half_flags_t f1val;        // halfword valids of f1
   logic        error_stall;
   logic        consume1;     // one buffer freed this cycle
   logic        consume2;     // two buffers freed this cycle
   logic        shift_2b;
   logic        shift_4b;
   logic        f0_shift_2b;  // low half of f0 used up
   logic        f1_shift_2b;  // low half of f1 used up

   modport valid_ctl (
      output f0val, f1val, error_stall, consume1, consume2,
      input  shift_2b, shift_4b, f1_shift_2b
   );

   modport aligner (
      output shift_2b, shift_4b, f0_shift_2b, f1_shift_2b,
      input  f0val, f1val, error_stall
   );

   modport buffer (
      input consume1, consume2, f0_shift_2b, f1_shift_2b
   );

endinterface

// File: ifu_aln_pkg.sv
//******************
// ifu aligner package
// widths, vector types and the fetch buffer count shared
// by the instruction aligner blocks
//******************

package ifu_aln_pkg;

   // ******************
   // widths
   // ******************

   localparam int XLEN   = 32;     // fetch and instruction width
   localparam int HALF_W = 16;     // one parcel

   // ring pointers wrap at this entry count
   localparam int NUM_FB = 3;

   // ******************
   // types
   // ******************

   // halfword granular pc without bit 0
   typedef logic [XLEN-1:1]   pc_t;

   // one fetch, or one aligned instruction
   typedef logic [XLEN-1:0]   fetch_word_t;

   // one 16 bit parcel
   typedef logic [HALF_W-1:0] half_t;

   // one bit per halfword with bit 0 the low half
   typedef logic [1:0]        half_flags_t;

   // access fault type from the fetch side
   typedef logic [1:0]        fault_type_t;

   // ring pointer over the buffer entries
   typedef logic [1:0]        fb_ptr_t;

endpackage

// File: ifu_aln_valid_ctl.sv
//******************
// aligner valid control
// f0/f1/f2 halfword valids, fetch routing, consume pulses
// and the error stall
//******************

`timescale 1ns/1ps

module ifu_aln_valid_ctl (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ifu_aln_pkg::half_flags_t  fetch_val,
   input  logic                      async_error_start,
   input  logic                      flush,
   aln_shift_if.valid_ctl            ctl
);
   import ifu_aln_pkg::*;

   half_flags_t f0val, f1val, f2val;
   half_flags_t f0val_in, f1val_in, f2val_in;
   half_flags_t sf0val, sf1val;               // after this cycle's shift
   logic        error_stall, error_stall_in;
   logic        sf0_valid, sf1_valid, f2_valid;
   logic        fetch_to_f0, fetch_to_f1, fetch_to_f2;
   logic        shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic        consume_fb0, consume_fb1;

   // ******************
   // remove what the aligner took
   // ******************

   always_comb begin
      if (ctl.shift_2b)
         sf0val = {1'b0, f0val[1]};
      else if (ctl.shift_4b)
         sf0val = 2'b00;
      else
         sf0val = f0val;
   end

   assign sf1val = ctl.f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   assign sf0_valid = sf0val[0];
   assign sf1_valid = sf1val[0];
   assign f2_valid  = f2val[0];

   // buffer emptied this cycle
   assign consume_fb0  = f0val[0] & ~sf0val[0];
   assign consume_fb1  = f1val[0] & ~sf1val[0];
   assign ctl.consume1 = consume_fb0 & ~consume_fb1 & ~flush;
   assign ctl.consume2 = consume_fb0 &  consume_fb1 & ~flush;

   // ******************
   // routing
   // ******************

   // older slots drain first
   assign shift_f1_f0 = ~sf0_valid &  sf1_valid;
   assign shift_f2_f0 = ~sf0_valid & ~sf1_valid & f2_valid;
   assign shift_f2_f1 = ~sf0_valid &  sf1_valid & f2_valid;

   assign fetch_to_f0 = fetch_val[0] & ~sf0_valid & ~sf1_valid & ~f2_valid;
   assign fetch_to_f1 = fetch_val[0] & (sf0_valid ^ sf1_valid ^ f2_valid)
                        & ~(sf0_valid & f2_valid);
   assign fetch_to_f2 = fetch_val[0] & ((sf1_valid & f2_valid & ~sf0_valid) |
                                        (sf0_valid & sf1_valid & ~f2_valid));

   always_comb begin
      if (flush)
         f0val_in = '0;
      else if (fetch_to_f0)
         f0val_in = fetch_val;
      else if (shift_f2_f0)
         f0val_in = f2val;
      else if (shift_f1_f0)
         f0val_in = sf1val;
      else
         f0val_in = sf0val;
   end

   always_comb begin
      if (flush)
         f1val_in = '0;
      else if (fetch_to_f1)
         f1val_in = fetch_val;
      else if (shift_f2_f1)
         f1val_in = f2val;
      else if (shift_f1_f0)
         f1val_in = '0;                       // moved down to f0
      else
         f1val_in = sf1val;
   end

   always_comb begin
      if (flush || (!fetch_to_f2 && (shift_f2_f1 || shift_f2_f0)))
         f2val_in = '0;
      else if (fetch_to_f2)
         f2val_in = fetch_val;
      else
         f2val_in = f2val;
   end

   // stall holds until the pipe flushes
   assign error_stall_in = (error_stall | async_error_start) & ~flush;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         f0val       <= '0;
         f1val       <= '0;
         f2val       <= '0;
         error_stall <= 1'b0;
      end else begin
         f0val       <= f0val_in;
         f1val       <= f1val_in;
         f2val       <= f2val_in;
         error_stall <= error_stall_in;
      end
   end

   assign ctl.f0val       = f0val;
   assign ctl.f1val       = f1val;
   assign ctl.error_stall = error_stall;

   // the oldest slot always starts on its low half
   a_f0_pattern: assert property (@(posedge clk) disable iff (!arst_n)
      f0val != 2'b10);

   // fetch side must honour the occupancy from the consume pulses
   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      (fetch_val[0] && !flush) |-> !(sf0_valid && sf1_valid && f2_valid));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the aligner testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module ifu_aligner_tb -f ifu_aligner.f

status=0
./obj_dir/Vifu_aligner_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" sim.log; then
   echo "simulation FAILED"
   exit 1
fi

echo "simulation PASSED"
exit 0

// File: tb_clock_gen.sv
//******************
// testbench clock and reset
// 40 ns clock, reset held low for 8 cycles
//******************

`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // half of the 40 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule
